/* Makefile */
# Verilator build and run for the rv_alu_core testbench

VERILATOR ?= verilator
TOP       ?= rv_alu_core_tb
BUILD     ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

/* sim/rv_alu_core_asserts.sv */
// rv_alu_core_asserts: handshake and retire timing properties, bound into rv_alu_core
`timescale 1ns/1ps

module rv_alu_core_asserts (
    input logic clk,
    input logic rst,
    input logic insn_valid,
    input logic insn_ready,
    input logic retire_valid
);

    logic transfer;
    assign transfer = insn_valid && insn_ready;      // input accepted on this edge

    // busy for decode, execute and writeback
    busy_after_transfer: assert property (@(posedge clk) disable iff (rst)
        transfer |-> ##1 !insn_ready ##1 !insn_ready ##1 !insn_ready)
        else $error("insn_ready high while an instruction is in flight");

    retire_follows_transfer: assert property (@(posedge clk) disable iff (rst)
        transfer |-> ##4 retire_valid)
        else $error("retire_valid missing four cycles after transfer");

    retire_single_pulse: assert property (@(posedge clk) disable iff (rst)
        retire_valid |=> !retire_valid)
        else $error("retire_valid held longer than one cycle");

    // no retire without an accepted instruction
    retire_has_source: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> $past(transfer, 4))
        else $error("retire_valid without a matching transfer");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !retire_valid)
        else $error("retire_valid high after reset");

endmodule

bind rv_alu_core rv_alu_core_asserts rv_alu_core_asserts_i (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .retire_valid (retire_valid)
);

/* sim/rv_alu_core_tb.sv */
// file-driven testbench with random input gaps, retire scoreboard and timeout
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu_core_tb;
    import rv_alu_pkg::*;

    localparam int          MAX_INSNS = 64;          // capacity of the data array
    localparam int          COLS      = 4;           // word, rd, value, illegal
    localparam logic [63:0] END_MARK  = '1;          // no 32-bit word can match this
    localparam logic [31:0] SEED      = 32'h3f455d93;

    logic        clk;
    logic        rst;
    logic        insn_valid;
    logic [31:0] insn;
    logic        insn_ready;
    logic        retire_valid;
    retire_t     retire;

    logic [63:0] tdata [0:MAX_INSNS*COLS-1];        // flat table of COLS entries per insn
    retire_t     expect_q [$];                       // scoreboard with oldest first
    int          n_insns;
    int          n_retired;
    int          cycles;
    int          cycle_limit;
    logic [31:0] lfsr;

    rv_alu_core rv_alu_core_i (
        .clk          (clk),
        .rst          (rst),
        .insn_valid   (insn_valid),
        .insn         (insn),
        .insn_ready   (insn_ready),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                            // 8 ns period

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        if (s[0]) begin
            n = (s >> 1) ^ 32'h80200003;
        end else begin
            n = s >> 1;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int nbits, output int val);
        val = 0;
        for (int b = 0; b < nbits; b++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic end_in_failure();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            end_in_failure();
        end
    endtask

    // number of rows before the end mark
    function automatic int count_entries();
        int n;
        n = 0;
        while (n < MAX_INSNS && tdata[n*COLS] != END_MARK) begin
            n++;
        end
        return n;
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic send_insn(input int idx);
        int      gap;
        retire_t e;
        draw_bits(2, gap);                           // 0 to 3 idle cycles
        while (!insn_ready) begin                    // previous word still in flight
            @(posedge clk);
            #1;
        end
        repeat (gap) begin                           // core ready and nothing offered
            @(posedge clk);
            #1;
        end
        e.pc      = 64'(idx) * 64'd4;                // pc predicted from position
        e.rd      = tdata[idx*COLS+1][4:0];
        e.value   = tdata[idx*COLS+2];
        e.illegal = tdata[idx*COLS+3][0];
        expect_q.push_back(e);
        insn_valid = 1'b1;
        insn       = tdata[idx*COLS][31:0];
        while (!insn_ready) begin                    // ready is stable here
            @(posedge clk);
            #1;
        end
        @(posedge clk);                              // transfer edge
        #1;
        insn_valid = 1'b0;
        insn       = '0;
    endtask

    // retire outputs are sampled mid-cycle
    always @(negedge clk) begin : retire_monitor
        retire_t e;
        if (!rst && retire_valid) begin
            if (expect_q.size() == 0) begin
                $display("retire seen with no instruction outstanding");
                end_in_failure();
            end
            e = expect_q.pop_front();
            compare("retire.pc", retire.pc, e.pc);
            compare("retire.rd", 64'(retire.rd), 64'(e.rd));
            compare("retire.value", retire.value, e.value);
            compare("retire.illegal", 64'(retire.illegal), 64'(e.illegal));
            n_retired++;
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d retired", cycles, n_retired, n_insns);
            end_in_failure();
        end
    end

    initial begin
        rst         = 1'b1;                          // every input set at time zero
        insn_valid  = 1'b0;
        insn        = '0;
        lfsr        = SEED;
        cycles      = 0;
        n_retired   = 0;
        n_insns     = 0;
        cycle_limit = 1000;                          // until the table length is known
        for (int i = 0; i < MAX_INSNS*COLS; i++) begin
            tdata[i] = END_MARK;
        end
        $readmemh("sim/rv_alu_testdata.txt", tdata);
        n_insns = count_entries();
        if (n_insns == 0) begin
            $display("test data file is empty or missing");
            end_in_failure();
        end
        cycle_limit = n_insns * 8 + 100;             // worst case 3 gap + 4 busy per insn
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_insns; i++) begin
            send_insn(i);
        end
        while (n_retired < n_insns) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);                   // catch a stray extra retire
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* sim/rv_alu_testdata.txt */
// columns: insn word, expected rd, expected retire value, expected illegal flag
// row n retires with pc 4*n
00500093 01 0000000000000005 0
FFD00113 02 FFFFFFFFFFFFFFFD 0
00112193 03 0000000000000001 0
00113213 04 0000000000000000 0
0FF0C293 05 00000000000000FA 0
0300E313 06 0000000000000035 0
0F017393 07 00000000000000F0 0
02809413 08 0000050000000000 0
40115493 09 FFFFFFFFFFFFFFFE 0
03C15513 0A 000000000000000F 0
002085B3 0B 0000000000000002 0
40208633 0C 0000000000000008 0
001126B3 0D 0000000000000001 0
00113733 0E 0000000000000000 0
0020C7B3 0F FFFFFFFFFFFFFFF8 0
00A09833 10 0000000000028000 0
001158B3 11 07FFFFFFFFFFFFFF 0
40115933 12 FFFFFFFFFFFFFFFF 0
0070E9B3 13 00000000000000F5 0
00617A33 14 0000000000000035 0
01E09A9B 15 0000000040000000 0
015A8B3B 16 FFFFFFFF80000000 0
404B5B9B 17 FFFFFFFFF8000000 0
00AB5C3B 18 0000000000010000 0
00909CBB 19 0000000040000000 0
12345D17 1A 0000000012345064 0
80000D97 1B FFFFFFFF80000068 0
0000B283 05 0000000000000000 1
00000063 00 0000000000000000 1
02208333 06 0000000000000000 1
00028E13 1C 00000000000000FA 0
00030E93 1D 0000000000000035 0
00708013 00 0000000000000000 0
00000F33 1E 0000000000000000 0

/* sources.f */
+incdir+verilog
verilog/rv_alu_pkg.sv
verilog/rv_opdecoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/fsm_alu.sv
verilog/rv_datapath.sv
verilog/rv_alu_core.sv
sim/rv_alu_core_asserts.sv
sim/rv_alu_core_tb.sv

/* verilog/fsm_alu.sv */
// fsm_alu: control FSM sequencing one instruction and issuing the datapath control word
`timescale 1ns/1ps

module fsm_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                accept,  // valid and ready on this edge
    input  rv_alu_pkg::decode_t dec,
    output rv_alu_pkg::ctrl_t   ctrl,
    output logic                idle
);
    import rv_alu_pkg::*;

    localparam logic [2:0] IDLE        = 3'b000;
    localparam logic [2:0] DECODE      = 3'b001;
    localparam logic [2:0] EXECUTE_REG = 3'b010;  // register form
    localparam logic [2:0] EXECUTE_IMM = 3'b011;  // immediate form and auipc
    localparam logic [2:0] WRITEBACK   = 3'b111;

    logic [2:0] state, next;
    ctrl_t      ctrl_q;    // loads registered from the next state
    logic       set_less;  // slt / sltu need the compare path

    assign set_less = (dec.funct3 == 3'b010) || (dec.funct3 == 3'b011);
    assign idle     = (state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next;
        end
    end

    // illegal words take the immediate slot with nothing loaded,
    // so every retire lands the same number of cycles after accept
    always_comb begin
        case (state)
            IDLE:        next = accept ? DECODE : IDLE;
            DECODE:      next = (dec.is_reg && !dec.illegal) ? EXECUTE_REG : EXECUTE_IMM;
            EXECUTE_REG: next = WRITEBACK;
            EXECUTE_IMM: next = WRITEBACK;
            WRITEBACK:   next = IDLE;
            default:     next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= '0;                                  // every enable is a one-cycle pulse
            case (next)
                DECODE: begin
                    ctrl_q.load_rs1 <= 1'b1;               // regfile ports to operand regs
                    ctrl_q.load_rs2 <= 1'b1;
                    ctrl_q.load_imm <= 1'b1;
                end
                EXECUTE_REG: begin
                    ctrl_q.load_alu <= 1'b1;
                    ctrl_q.sub_sra  <= set_less ? 1'b1 : dec.bit30; // sub, sra, slt, sltu
                    ctrl_q.word     <= dec.is_word;
                    ctrl_q.func3    <= dec.funct3;
                end
                EXECUTE_IMM: begin
                    ctrl_q.load_alu  <= !dec.illegal;
                    ctrl_q.sel_alu_a <= dec.is_auipc;      // pc as operand a
                    ctrl_q.sel_alu_b <= 1'b1;              // immediate as operand b
                    ctrl_q.sub_sra   <= (dec.funct3 == 3'b101) ? dec.bit30 : set_less;
                    ctrl_q.word      <= dec.is_word;
                    ctrl_q.func3     <= dec.funct3;
                end
                WRITEBACK: begin
                    ctrl_q.load_regfile <= !dec.illegal;   // illegal leaves rd untouched
                    ctrl_q.load_pc      <= 1'b1;           // pc advances either way
                end
                default: begin
                    ctrl_q <= '0;
                end
            endcase
        end
    end

    always_comb begin
        ctrl          = ctrl_q;
        ctrl.load_ins = accept;  // instruction register captures on the transfer edge
    end

endmodule

/* verilog/rv_alu.sv */
// rv_alu: 64-bit integer alu with the 32-bit word-mode variants
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  logic [2:0]          func3,
    input  logic                sub_sra,
    input  logic                word,
    output logic [`RV_XLEN-1:0] y
);

    logic [5:0]          shamt;     // 5 bits in word mode
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] shr_src;   // operand prepared for right shifts
    logic [`RV_XLEN-1:0] shr;
    logic [`RV_XLEN-1:0] res;

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];
    assign sum   = sub_sra ? (a - b) : (a + b);

    // word mode shifts the low half, zero or sign filled from bit 31
    always_comb begin
        if (word) begin
            shr_src = sub_sra ? {{(`RV_XLEN-32){a[31]}}, a[31:0]}
                              : {{(`RV_XLEN-32){1'b0}}, a[31:0]};
        end else begin
            shr_src = a;
        end
    end

    assign shr = sub_sra ? $unsigned($signed(shr_src) >>> shamt) : (shr_src >> shamt);

    always_comb begin
        case (func3)
            3'b000:  res = sum;                                        // add / sub
            3'b001:  res = a << shamt;                                 // sll
            3'b010:  res = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)}; // slt
            3'b011:  res = {{(`RV_XLEN-1){1'b0}}, a < b};              // sltu
            3'b100:  res = a ^ b;                                      // xor
            3'b101:  res = shr;                                        // srl / sra
            3'b110:  res = a | b;                                      // or
            3'b111:  res = a & b;                                      // and
            default: res = '0;
        endcase
    end

    // W results are the low 32 bits sign-extended
    assign y = word ? {{(`RV_XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

/* verilog/rv_alu_core.sv */
// rv_alu_core: top level joining the decoder, control FSM and datapath
`timescale 1ns/1ps

module rv_alu_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                insn_valid,
    input  logic [31:0]         insn,
    output logic                insn_ready,
    output logic                retire_valid,
    output rv_alu_pkg::retire_t retire
);
    import rv_alu_pkg::*;

    logic [31:0] insn_q;  // held word, stable until the next accept
    decode_t     dec;
    ctrl_t       ctrl;
    logic        accept;  // input transfer on this edge

    assign accept = insn_valid && insn_ready;

    rv_opdecoder rv_opdecoder_i (
        .insn (insn_q),
        .dec  (dec)
    );

    fsm_alu fsm_alu_i (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .dec    (dec),
        .ctrl   (ctrl),
        .idle   (insn_ready)  // ready only between instructions
    );

    rv_datapath rv_datapath_i (
        .clk          (clk),
        .rst          (rst),
        .insn_in      (insn),
        .ctrl         (ctrl),
        .dec          (dec),
        .insn_q       (insn_q),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* verilog/rv_alu_pkg.sv */
// decode_t, ctrl_t and retire_t records shared by the alu core blocks
`include "rv_consts.svh"

package rv_alu_pkg;

    // decoder output for the word held in the instruction register
    typedef struct packed {
        logic                is_reg;    // OP or OP-32, operand b from rs2
        logic                is_word;   // 32-bit W form
        logic                is_auipc;  // operand a from pc
        logic                illegal;   // outside the supported group
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [2:0]          funct3;    // forced to add for auipc
        logic                bit30;     // sub / sra select bit
        logic [`RV_XLEN-1:0] imm;       // sign-extended, I or U type
    } decode_t;

    // fsm control word, applied by the datapath on the next edge
    typedef struct packed {
        logic       load_ins;      // capture instruction word
        logic       load_rs1;      // capture regfile port 1
        logic       load_rs2;      // capture regfile port 2
        logic       load_imm;      // capture immediate
        logic       load_alu;      // capture alu result
        logic       load_regfile;  // write rd
        logic       load_pc;       // pc += 4 and retire
        logic       sel_alu_a;     // 0 rs1, 1 pc
        logic       sel_alu_b;     // 0 rs2, 1 imm
        logic       sub_sra;       // subtract / arithmetic shift
        logic       word;          // 32-bit operation
        logic [2:0] func3;         // alu function
    } ctrl_t;

    // one completed instruction
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;       // pc of the retired instruction
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;    // zero for illegal or x0
        logic                illegal;
    } retire_t;

endpackage

/* verilog/rv_consts.svh */
// word width, register count, reset pc and major opcode values for the alu core
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath geometry
`define RV_XLEN      64          // integer register width
`define RV_NREGS     32          // x0..x31

// pc value right after reset
`define RV_RESET_PC  64'h0

// major opcodes, insn[6:0]
`define RV_OP_OP     7'b0110011  // add sub sll slt sltu xor srl sra or and
`define RV_OP_IMM    7'b0010011  // addi slti sltiu xori ori andi slli srli srai
`define RV_OP_OP32   7'b0111011  // addw subw sllw srlw sraw
`define RV_OP_IMM32  7'b0011011  // addiw slliw srliw sraiw
`define RV_OP_AUIPC  7'b0010111  // pc + upper immediate

`endif

/* verilog/rv_datapath.sv */
// rv_datapath: pc, instruction, operand and result registers, operand muxes, retire record
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_datapath (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         insn_in,
    input  rv_alu_pkg::ctrl_t   ctrl,
    input  rv_alu_pkg::decode_t dec,
    output logic [31:0]         insn_q,
    output logic                retire_valid,
    output rv_alu_pkg::retire_t retire
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] rs1_q, rs2_q;   // operands latched in decode
    logic [`RV_XLEN-1:0] imm_q;
    logic [`RV_XLEN-1:0] alu_q;          // result latched in execute
    logic [`RV_XLEN-1:0] rdata1, rdata2;
    logic [`RV_XLEN-1:0] alu_a, alu_b, alu_y;
    logic [`RV_XLEN-1:0] wb_value;       // value reported on retire

    rv_regfile rv_regfile_i (
        .clk    (clk),
        .rst    (rst),
        .we     (ctrl.load_regfile),
        .waddr  (dec.rd),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata  (alu_q),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_a = ctrl.sel_alu_a ? pc_q : rs1_q;   // auipc uses the pc
    assign alu_b = ctrl.sel_alu_b ? imm_q : rs2_q;

    rv_alu rv_alu_i (
        .a       (alu_a),
        .b       (alu_b),
        .func3   (ctrl.func3),
        .sub_sra (ctrl.sub_sra),
        .word    (ctrl.word),
        .y       (alu_y)
    );

    assign wb_value = (dec.illegal || (dec.rd == 5'd0)) ? '0 : alu_q;

    always_ff @(posedge clk) begin
        if (ctrl.load_ins) insn_q <= insn_in;
        if (ctrl.load_rs1) rs1_q  <= rdata1;
        if (ctrl.load_rs2) rs2_q  <= rdata2;
        if (ctrl.load_imm) imm_q  <= dec.imm;
        if (ctrl.load_alu) alu_q  <= alu_y;
        if (ctrl.load_pc) begin
            retire.pc      <= pc_q;          // pc before the increment
            retire.rd      <= dec.rd;
            retire.value   <= wb_value;
            retire.illegal <= dec.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q         <= `RV_RESET_PC;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ctrl.load_pc;    // one pulse per finished instruction
            if (ctrl.load_pc) begin
                pc_q <= pc_q + `RV_XLEN'd4;
            end
        end
    end

endmodule

/* verilog/rv_opdecoder.sv */
// rv_opdecoder: classifies the instruction word and builds the sign-extended immediate
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_opdecoder (
    input  logic [31:0]         insn,
    output rv_alu_pkg::decode_t dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       is_op, is_imm, is_op32, is_imm32, is_auipc;
    logic       f7_zero, f7_alt;  // funct7 for register and W shift forms
    logic       f6_zero, f6_alt;  // funct6 for rv64 immediate shifts, shamt is 6 bits
    logic       legal;

    assign opcode   = insn[6:0];
    assign funct3   = insn[14:12];
    assign funct7   = insn[31:25];

    assign is_op    = (opcode == `RV_OP_OP);
    assign is_imm   = (opcode == `RV_OP_IMM);
    assign is_op32  = (opcode == `RV_OP_OP32);
    assign is_imm32 = (opcode == `RV_OP_IMM32);
    assign is_auipc = (opcode == `RV_OP_AUIPC);

    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);
    assign f6_zero  = (insn[31:26] == 6'b000000);
    assign f6_alt   = (insn[31:26] == 6'b010000);

    always_comb begin
        legal = 1'b0;
        if (is_op) begin
            legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)); // sub, sra
        end else if (is_imm) begin
            case (funct3)
                3'b001:  legal = f6_zero;            // slli
                3'b101:  legal = f6_zero || f6_alt;  // srli / srai
                default: legal = 1'b1;
            endcase
        end else if (is_op32) begin
            case (funct3)
                3'b000:  legal = f7_zero || f7_alt;  // addw / subw
                3'b001:  legal = f7_zero;            // sllw
                3'b101:  legal = f7_zero || f7_alt;  // srlw / sraw
                default: legal = 1'b0;               // no slt/logic in W forms
            endcase
        end else if (is_imm32) begin
            case (funct3)
                3'b000:  legal = 1'b1;               // addiw
                3'b001:  legal = f7_zero;            // slliw
                3'b101:  legal = f7_zero || f7_alt;  // srliw / sraiw
                default: legal = 1'b0;
            endcase
        end else if (is_auipc) begin
            legal = 1'b1;
        end
    end

    always_comb begin
        dec.is_reg   = is_op || is_op32;
        dec.is_word  = is_op32 || is_imm32;
        dec.is_auipc = is_auipc;
        dec.illegal  = !legal;
        dec.rs1      = insn[19:15];
        dec.rs2      = insn[24:20];
        dec.rd       = insn[11:7];
        dec.funct3   = is_auipc ? 3'b000 : funct3;   // upper imm bits, not a function
        dec.bit30    = is_auipc ? 1'b0 : insn[30];
        dec.imm      = is_auipc ? {{(`RV_XLEN-32){insn[31]}}, insn[31:12], 12'b0}
                                : {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
    end

endmodule

/* verilog/rv_regfile.sv */
// rv_regfile: 32 x 64 register file, x0 reads zero, two read ports
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  logic [4:0]          waddr,
    input  logic [4:0]          raddr1,
    input  logic [4:0]          raddr2,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;                    // architectural state starts at zero
            end
        end else if (we && (waddr != 5'd0)) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];  // combinational read
    assign rdata2 = regs[raddr2];

endmodule
